//--- common/rv64_defines.svh
// core width, register count, data memory depth and reset pc macros
`ifndef RV64_DEFINES_SVH
`define RV64_DEFINES_SVH

// data path width
`define XLEN 64

// architectural registers
`define NUM_REGS 32

// data memory depth in doublewords
`define DMEM_WORDS 256

`define RESET_PC 64'h0

`endif

//--- common/rv64_pkg.sv
// word typedefs and control enums shared by the rv64 core
`default_nettype none

`include "rv64_defines.svh"

package rv64_pkg;

  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [4:0] reg_idx_t;

  // alu selector codes
  typedef enum logic [4:0] {
    alu_add  = 5'b00000,
    alu_sub  = 5'b00001,
    alu_slt  = 5'b00010,
    alu_sltu = 5'b00011,
    alu_xor  = 5'b00100,
    alu_and  = 5'b00101,
    alu_or   = 5'b00110,
    alu_sll  = 5'b00111,
    alu_srl  = 5'b01000,
    alu_sra  = 5'b01001,
    alu_mul  = 5'b01010,
    alu_div  = 5'b01011,
    alu_divu = 5'b01100,
    alu_rem  = 5'b01101,
    alu_remu = 5'b01110,
    alu_copy = 5'b01111
  } alu_op_e;

  // unsigned compares pick alu_sltu with blt/bge
  typedef enum logic [2:0] {
    br_none = 3'b000,
    br_jal  = 3'b001,
    br_jalr = 3'b010,
    br_beq  = 3'b100,
    br_bne  = 3'b101,
    br_blt  = 3'b110,
    br_bge  = 3'b111
  } branch_e;

  // bits [2:1] carry the access size for stores
  typedef enum logic [2:0] {
    mem_lb  = 3'b000,
    mem_lbu = 3'b001,
    mem_lh  = 3'b010,
    mem_lhu = 3'b011,
    mem_lw  = 3'b100,
    mem_lwu = 3'b101,
    mem_ld  = 3'b110
  } mem_op_e;

  typedef enum logic [3:0] {
    ex_normal  = 4'b0000,
    ex_ebreak  = 4'b1110,
    ex_invalid = 4'b1111
  } ex_ctrl_e;

  typedef enum logic {
    a_rs1 = 1'b0,
    a_pc  = 1'b1
  } alu_a_src_e;

  typedef enum logic [1:0] {
    b_rs2  = 2'b00,
    b_imm  = 2'b01,
    b_four = 2'b10
  } alu_b_src_e;

endpackage

`default_nettype wire

//--- idu/rv64_idu.sv
// instruction decoder producing register indices, immediates and control enums
`default_nettype none
`timescale 1ns/100ps

`include "rv64_defines.svh"

module rv64_idu (
  input  logic                 [31:0] i_inst,
  output rv64_pkg::reg_idx_t          o_rd,
  output rv64_pkg::reg_idx_t          o_rs1,
  output rv64_pkg::reg_idx_t          o_rs2,
  output rv64_pkg::xlen_t             o_imm,
  output rv64_pkg::alu_op_e           o_alu_op,
  output rv64_pkg::alu_a_src_e        o_alu_a_src,
  output rv64_pkg::alu_b_src_e        o_alu_b_src,
  output logic                        o_word_cut,
  output rv64_pkg::branch_e           o_branch,
  output rv64_pkg::mem_op_e           o_mem_op,
  output logic                        o_mem_read,
  output logic                        o_mem_write,
  output logic                        o_mem_to_reg,
  output logic                        o_reg_write,
  output rv64_pkg::ex_ctrl_e          o_ex_ctrl
);

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_imm32  = 7'b0011011,
    op_reg    = 7'b0110011,
    op_reg32  = 7'b0111011,
    op_system = 7'b1110011
  } opcode_e;

  opcode_e              opcode;
  logic          [2:0]  funct3;
  logic          [6:0]  funct7;
  logic                 is_shift;
  logic                 shamt_bad;
  rv64_pkg::xlen_t      imm_i;
  rv64_pkg::xlen_t      imm_s;
  rv64_pkg::xlen_t      imm_b;
  rv64_pkg::xlen_t      imm_u;
  rv64_pkg::xlen_t      imm_j;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rd  = i_inst[11:7];
  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // immediate shifts only allow bit 30, and word forms keep shamt below 32
  assign is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);
  assign shamt_bad = (|{i_inst[31], i_inst[29:26]}) || (funct3 == 3'b001 && i_inst[30]) ||
                     (opcode == op_imm32 && i_inst[25]);

  always_comb begin
    o_imm        = imm_i;
    o_alu_op     = rv64_pkg::alu_add;
    o_alu_a_src  = rv64_pkg::a_rs1;
    o_alu_b_src  = rv64_pkg::b_imm;
    o_word_cut   = 1'b0;
    o_branch     = rv64_pkg::br_none;
    o_mem_op     = rv64_pkg::mem_ld;
    o_mem_read   = 1'b0;
    o_mem_write  = 1'b0;
    o_mem_to_reg = 1'b0;
    o_reg_write  = 1'b0;
    o_ex_ctrl    = rv64_pkg::ex_normal;
    case (opcode)
      op_lui: begin
        o_imm       = imm_u;
        o_alu_op    = rv64_pkg::alu_copy;
        o_reg_write = 1'b1;
      end
      op_auipc: begin
        o_imm       = imm_u;
        o_alu_a_src = rv64_pkg::a_pc;
        o_reg_write = 1'b1;
      end
      op_jal: begin
        o_imm       = imm_j;
        o_alu_a_src = rv64_pkg::a_pc;
        o_alu_b_src = rv64_pkg::b_four;
        o_branch    = rv64_pkg::br_jal;
        o_reg_write = 1'b1;
      end
      op_jalr: begin
        o_alu_a_src = rv64_pkg::a_pc;
        o_alu_b_src = rv64_pkg::b_four;
        o_branch    = rv64_pkg::br_jalr;
        o_reg_write = 1'b1;
        if (funct3 != 3'b000) o_ex_ctrl = rv64_pkg::ex_invalid;
      end
      op_branch: begin
        o_imm       = imm_b;
        o_alu_b_src = rv64_pkg::b_rs2;
        o_alu_op    = funct3[1] ? rv64_pkg::alu_sltu : rv64_pkg::alu_slt;
        case (funct3)
          3'b000: o_branch = rv64_pkg::br_beq;
          3'b001: o_branch = rv64_pkg::br_bne;
          3'b100, 3'b110: o_branch = rv64_pkg::br_blt;
          3'b101, 3'b111: o_branch = rv64_pkg::br_bge;
          default: o_ex_ctrl = rv64_pkg::ex_invalid;
        endcase
        // beq/bne only look at the subtract zero flag
        if (!funct3[2]) o_alu_op = rv64_pkg::alu_sub;
      end
      op_load: begin
        o_mem_read   = 1'b1;
        o_mem_to_reg = 1'b1;
        o_reg_write  = 1'b1;
        case (funct3)
          3'b000: o_mem_op = rv64_pkg::mem_lb;
          3'b001: o_mem_op = rv64_pkg::mem_lh;
          3'b010: o_mem_op = rv64_pkg::mem_lw;
          3'b011: o_mem_op = rv64_pkg::mem_ld;
          3'b100: o_mem_op = rv64_pkg::mem_lbu;
          3'b101: o_mem_op = rv64_pkg::mem_lhu;
          3'b110: o_mem_op = rv64_pkg::mem_lwu;
          default: o_ex_ctrl = rv64_pkg::ex_invalid;
        endcase
      end
      op_store: begin
        o_imm       = imm_s;
        o_mem_write = 1'b1;
        case (funct3)
          3'b000: o_mem_op = rv64_pkg::mem_lb;
          3'b001: o_mem_op = rv64_pkg::mem_lh;
          3'b010: o_mem_op = rv64_pkg::mem_lw;
          3'b011: o_mem_op = rv64_pkg::mem_ld;
          default: o_ex_ctrl = rv64_pkg::ex_invalid;
        endcase
      end
      op_imm, op_imm32: begin
        o_reg_write = 1'b1;
        o_word_cut  = (opcode == op_imm32);
        case (funct3)
          3'b000: o_alu_op = rv64_pkg::alu_add;
          3'b001: o_alu_op = rv64_pkg::alu_sll;
          3'b010: o_alu_op = rv64_pkg::alu_slt;
          3'b011: o_alu_op = rv64_pkg::alu_sltu;
          3'b100: o_alu_op = rv64_pkg::alu_xor;
          3'b101: o_alu_op = i_inst[30] ? rv64_pkg::alu_sra : rv64_pkg::alu_srl;
          3'b110: o_alu_op = rv64_pkg::alu_or;
          default: o_alu_op = rv64_pkg::alu_and;
        endcase
        if (is_shift && shamt_bad) o_ex_ctrl = rv64_pkg::ex_invalid;
        if (o_word_cut && !(is_shift || funct3 == 3'b000)) o_ex_ctrl = rv64_pkg::ex_invalid;
      end
      op_reg, op_reg32: begin
        o_alu_b_src = rv64_pkg::b_rs2;
        o_reg_write = 1'b1;
        o_word_cut  = (opcode == op_reg32);
        case ({funct7, funct3})
          10'b0000000_000: o_alu_op = rv64_pkg::alu_add;
          10'b0100000_000: o_alu_op = rv64_pkg::alu_sub;
          10'b0000000_001: o_alu_op = rv64_pkg::alu_sll;
          10'b0000000_010: o_alu_op = rv64_pkg::alu_slt;
          10'b0000000_011: o_alu_op = rv64_pkg::alu_sltu;
          10'b0000000_100: o_alu_op = rv64_pkg::alu_xor;
          10'b0000000_101: o_alu_op = rv64_pkg::alu_srl;
          10'b0100000_101: o_alu_op = rv64_pkg::alu_sra;
          10'b0000000_110: o_alu_op = rv64_pkg::alu_or;
          10'b0000000_111: o_alu_op = rv64_pkg::alu_and;
          10'b0000001_000: o_alu_op = rv64_pkg::alu_mul;
          10'b0000001_100: o_alu_op = rv64_pkg::alu_div;
          10'b0000001_101: o_alu_op = rv64_pkg::alu_divu;
          10'b0000001_110: o_alu_op = rv64_pkg::alu_rem;
          10'b0000001_111: o_alu_op = rv64_pkg::alu_remu;
          // mulh family is not supported
          default: o_ex_ctrl = rv64_pkg::ex_invalid;
        endcase
        if (o_word_cut && o_alu_op inside {rv64_pkg::alu_slt, rv64_pkg::alu_sltu,
            rv64_pkg::alu_xor, rv64_pkg::alu_or, rv64_pkg::alu_and}) begin
          o_ex_ctrl = rv64_pkg::ex_invalid;
        end
      end
      op_system: begin
        if (i_inst == 32'h0010_0073) o_ex_ctrl = rv64_pkg::ex_ebreak;
        else o_ex_ctrl = rv64_pkg::ex_invalid;
      end
      default: o_ex_ctrl = rv64_pkg::ex_invalid;
    endcase
    // nothing retires state for ebreak or a bad encoding
    if (o_ex_ctrl != rv64_pkg::ex_normal) begin
      o_reg_write  = 1'b0;
      o_mem_write  = 1'b0;
      o_mem_read   = 1'b0;
      o_mem_to_reg = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- exu/rv64_exu.sv
// execute unit with alu, branch resolution, next pc, load extension and write-back select
`default_nettype none
`timescale 1ns/100ps

`include "rv64_defines.svh"

module rv64_exu (
  input  rv64_pkg::xlen_t      i_rs1,
  input  rv64_pkg::xlen_t      i_rs2,
  input  rv64_pkg::xlen_t      i_imm,
  input  rv64_pkg::xlen_t      i_pc,
  input  rv64_pkg::xlen_t      i_rdata,
  input  rv64_pkg::alu_a_src_e i_alu_a_src,
  input  rv64_pkg::alu_b_src_e i_alu_b_src,
  input  rv64_pkg::alu_op_e    i_alu_op,
  input  logic                 i_word_cut,
  input  rv64_pkg::branch_e    i_branch,
  input  rv64_pkg::mem_op_e    i_mem_op,
  input  logic                 i_mem_to_reg,
  output rv64_pkg::xlen_t      o_alu_result,
  output rv64_pkg::xlen_t      o_next_pc,
  output rv64_pkg::xlen_t      o_wb_data
);

  rv64_pkg::xlen_t a_sel;
  rv64_pkg::xlen_t b_sel;
  rv64_pkg::xlen_t src_a;
  rv64_pkg::xlen_t src_b;
  rv64_pkg::xlen_t sub_result;
  rv64_pkg::xlen_t quot_s;
  rv64_pkg::xlen_t rem_s;
  rv64_pkg::xlen_t div_q;
  rv64_pkg::xlen_t divu_q;
  rv64_pkg::xlen_t rem_r;
  rv64_pkg::xlen_t remu_r;
  rv64_pkg::xlen_t alu_raw;
  rv64_pkg::xlen_t target_sum;
  rv64_pkg::xlen_t load_ext;
  logic      [5:0] shamt;
  logic            signed_cut;
  logic            borrow;
  logic            zero;
  logic            overflow;
  logic            less;
  logic            div_zero;
  logic            div_ovf;
  logic            take;
  logic            jump_reg;

  assign a_sel = (i_alu_a_src == rv64_pkg::a_pc) ? i_pc : i_rs1;

  always_comb begin
    case (i_alu_b_src)
      rv64_pkg::b_rs2: b_sel = i_rs2;
      rv64_pkg::b_imm: b_sel = i_imm;
      default:         b_sel = `XLEN'd4;
    endcase
  end

  // word forms keep the low half, sign-extended where the op is signed
  assign signed_cut = i_alu_op inside {rv64_pkg::alu_sra, rv64_pkg::alu_div, rv64_pkg::alu_rem};
  assign src_a = i_word_cut ? {{(`XLEN-32){signed_cut & a_sel[31]}}, a_sel[31:0]} : a_sel;
  assign src_b = i_word_cut ? {{(`XLEN-32){signed_cut & b_sel[31]}}, b_sel[31:0]} : b_sel;
  assign shamt = i_word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];

  // compare flags from the subtractor
  assign {borrow, sub_result} = {1'b0, src_a} - {1'b0, src_b};
  assign zero     = ~(|sub_result);
  assign overflow = (src_a[`XLEN-1] ^ src_b[`XLEN-1]) & (sub_result[`XLEN-1] ^ src_a[`XLEN-1]);
  assign less     = (i_alu_op == rv64_pkg::alu_sltu) ? borrow : (sub_result[`XLEN-1] ^ overflow);

  // signed quotient and remainder on their own so the operators stay signed
  assign quot_s   = $signed(src_a) / $signed(src_b);
  assign rem_s    = $signed(src_a) % $signed(src_b);

  // riscv divide by zero and overflow results
  assign div_zero = (src_b == '0);
  assign div_ovf  = (src_a == {1'b1, {(`XLEN-1){1'b0}}}) && (&src_b);
  assign div_q    = div_zero ? '1 : div_ovf ? src_a : quot_s;
  assign rem_r    = div_zero ? src_a : div_ovf ? '0 : rem_s;
  assign divu_q   = div_zero ? '1 : src_a / src_b;
  assign remu_r   = div_zero ? src_a : src_a % src_b;

  always_comb begin
    case (i_alu_op)
      rv64_pkg::alu_copy: alu_raw = i_imm;
      rv64_pkg::alu_sub:  alu_raw = sub_result;
      rv64_pkg::alu_slt:  alu_raw = {{(`XLEN-1){1'b0}}, less};
      rv64_pkg::alu_sltu: alu_raw = {{(`XLEN-1){1'b0}}, less};
      rv64_pkg::alu_xor:  alu_raw = src_a ^ src_b;
      rv64_pkg::alu_and:  alu_raw = src_a & src_b;
      rv64_pkg::alu_or:   alu_raw = src_a | src_b;
      rv64_pkg::alu_sll:  alu_raw = src_a << shamt;
      rv64_pkg::alu_srl:  alu_raw = src_a >> shamt;
      rv64_pkg::alu_sra:  alu_raw = $signed(src_a) >>> shamt;
      rv64_pkg::alu_mul:  alu_raw = src_a * src_b;
      rv64_pkg::alu_div:  alu_raw = div_q;
      rv64_pkg::alu_divu: alu_raw = divu_q;
      rv64_pkg::alu_rem:  alu_raw = rem_r;
      rv64_pkg::alu_remu: alu_raw = remu_r;
      default:            alu_raw = src_a + src_b;
    endcase
  end

  assign o_alu_result = i_word_cut ? {{(`XLEN-32){alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  always_comb begin
    case (i_branch)
      rv64_pkg::br_jal,
      rv64_pkg::br_jalr: take = 1'b1;
      rv64_pkg::br_beq:  take = zero;
      rv64_pkg::br_bne:  take = ~zero;
      rv64_pkg::br_blt:  take = less;
      rv64_pkg::br_bge:  take = ~less;
      default:           take = 1'b0;
    endcase
  end

  assign jump_reg   = (i_branch == rv64_pkg::br_jalr);
  assign target_sum = (jump_reg ? i_rs1 : i_pc) + (take ? i_imm : `XLEN'd4);
  assign o_next_pc  = jump_reg ? {target_sum[`XLEN-1:1], 1'b0} : target_sum;

  always_comb begin
    case (i_mem_op)
      rv64_pkg::mem_lb:  load_ext = {{(`XLEN-8){i_rdata[7]}}, i_rdata[7:0]};
      rv64_pkg::mem_lbu: load_ext = {{(`XLEN-8){1'b0}}, i_rdata[7:0]};
      rv64_pkg::mem_lh:  load_ext = {{(`XLEN-16){i_rdata[15]}}, i_rdata[15:0]};
      rv64_pkg::mem_lhu: load_ext = {{(`XLEN-16){1'b0}}, i_rdata[15:0]};
      rv64_pkg::mem_lw:  load_ext = {{(`XLEN-32){i_rdata[31]}}, i_rdata[31:0]};
      rv64_pkg::mem_lwu: load_ext = {{(`XLEN-32){1'b0}}, i_rdata[31:0]};
      default:           load_ext = i_rdata;
    endcase
  end

  assign o_wb_data = i_mem_to_reg ? load_ext : o_alu_result;

endmodule

`default_nettype wire

//--- rtl/rv64_regfile.sv
// general purpose register file with two read ports, one write port and x0 tied to zero
`default_nettype none
`timescale 1ns/100ps

`include "rv64_defines.svh"

module rv64_regfile (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_we,
  input  rv64_pkg::reg_idx_t i_waddr,
  input  rv64_pkg::reg_idx_t i_raddr1,
  input  rv64_pkg::reg_idx_t i_raddr2,
  input  rv64_pkg::xlen_t    i_wdata,
  output rv64_pkg::xlen_t    o_rdata1,
  output rv64_pkg::xlen_t    o_rdata2
);

  rv64_pkg::xlen_t regs [`NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

//--- rtl/rv64_lsu.sv
// data memory with byte-masked stores and shifted doubleword reads
`default_nettype none
`timescale 1ns/100ps

`include "rv64_defines.svh"

module rv64_lsu (
  input  logic              i_clk,
  input  logic              i_we,
  input  rv64_pkg::xlen_t   i_addr,
  input  rv64_pkg::xlen_t   i_wdata,
  input  rv64_pkg::mem_op_e i_mem_op,
  output rv64_pkg::xlen_t   o_rdata
);

  localparam int idx_w = $clog2(`DMEM_WORDS);

  rv64_pkg::xlen_t       mem [`DMEM_WORDS];
  logic      [idx_w-1:0] word_idx;
  logic            [2:0] byte_off;
  logic            [7:0] size_mask;
  logic            [7:0] byte_en;
  rv64_pkg::xlen_t       wdata_sh;

  // upper address bits wrap around the memory depth
  assign word_idx = i_addr[3 +: idx_w];
  assign byte_off = i_addr[2:0];

  // addressed byte lands at bit 0
  assign o_rdata = mem[word_idx] >> {byte_off, 3'b000};

  always_comb begin
    case (i_mem_op)
      rv64_pkg::mem_lb, rv64_pkg::mem_lbu: size_mask = 8'h01;
      rv64_pkg::mem_lh, rv64_pkg::mem_lhu: size_mask = 8'h03;
      rv64_pkg::mem_lw, rv64_pkg::mem_lwu: size_mask = 8'h0f;
      default:                             size_mask = 8'hff;
    endcase
  end

  assign byte_en  = size_mask << byte_off;
  assign wdata_sh = i_wdata << {byte_off, 3'b000};

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      for (int i = 0; i < 8; i++) begin
        if (byte_en[i]) mem[word_idx][i*8 +: 8] <= wdata_sh[i*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv64_core.sv
// single-cycle core top with pc register, decoder, register file, execute unit and data memory
`default_nettype none
`timescale 1ns/100ps

`include "rv64_defines.svh"

module rv64_core (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic        [31:0] i_inst,
  output rv64_pkg::xlen_t    o_pc,
  output logic               o_wb_valid,
  output rv64_pkg::reg_idx_t o_wb_rd,
  output rv64_pkg::xlen_t    o_wb_data,
  output logic               o_halt,
  output logic               o_abort
);

  rv64_pkg::reg_idx_t   rd;
  rv64_pkg::reg_idx_t   rs1;
  rv64_pkg::reg_idx_t   rs2;
  rv64_pkg::xlen_t      imm;
  rv64_pkg::alu_op_e    alu_op;
  rv64_pkg::alu_a_src_e alu_a_src;
  rv64_pkg::alu_b_src_e alu_b_src;
  logic                 word_cut;
  rv64_pkg::branch_e    branch;
  rv64_pkg::mem_op_e    mem_op;
  logic                 mem_read;
  logic                 mem_write;
  logic                 mem_to_reg;
  logic                 reg_write;
  rv64_pkg::ex_ctrl_e   ex_ctrl;
  rv64_pkg::xlen_t      rs1_data;
  rv64_pkg::xlen_t      rs2_data;
  rv64_pkg::xlen_t      alu_result;
  rv64_pkg::xlen_t      next_pc;
  rv64_pkg::xlen_t      wb_data;
  rv64_pkg::xlen_t      mem_rdata;
  rv64_pkg::xlen_t      mem_addr;
  logic                 stopped;
  logic                 rf_we;

  assign stopped  = o_halt | o_abort;
  assign rf_we    = reg_write & ~stopped;
  // address bus idles at zero when there is no access
  assign mem_addr = (mem_read | mem_write) ? alu_result : '0;

  rv64_idu u_idu (
    .i_inst       (i_inst),
    .o_rd         (rd),
    .o_rs1        (rs1),
    .o_rs2        (rs2),
    .o_imm        (imm),
    .o_alu_op     (alu_op),
    .o_alu_a_src  (alu_a_src),
    .o_alu_b_src  (alu_b_src),
    .o_word_cut   (word_cut),
    .o_branch     (branch),
    .o_mem_op     (mem_op),
    .o_mem_read   (mem_read),
    .o_mem_write  (mem_write),
    .o_mem_to_reg (mem_to_reg),
    .o_reg_write  (reg_write),
    .o_ex_ctrl    (ex_ctrl)
  );

  rv64_regfile u_regfile (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_we     (rf_we),
    .i_waddr  (rd),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wdata  (wb_data),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data)
  );

  rv64_exu u_exu (
    .i_rs1        (rs1_data),
    .i_rs2        (rs2_data),
    .i_imm        (imm),
    .i_pc         (o_pc),
    .i_rdata      (mem_rdata),
    .i_alu_a_src  (alu_a_src),
    .i_alu_b_src  (alu_b_src),
    .i_alu_op     (alu_op),
    .i_word_cut   (word_cut),
    .i_branch     (branch),
    .i_mem_op     (mem_op),
    .i_mem_to_reg (mem_to_reg),
    .o_alu_result (alu_result),
    .o_next_pc    (next_pc),
    .o_wb_data    (wb_data)
  );

  rv64_lsu u_lsu (
    .i_clk    (i_clk),
    .i_we     (mem_write & ~stopped),
    .i_addr   (mem_addr),
    .i_wdata  (rs2_data),
    .i_mem_op (mem_op),
    .o_rdata  (mem_rdata)
  );

  // pc, status and write-back report
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pc       <= `RESET_PC;
      o_wb_valid <= 1'b0;
      o_halt     <= 1'b0;
      o_abort    <= 1'b0;
    end else begin
      if (!stopped) o_pc <= next_pc;
      o_wb_valid <= rf_we && (rd != '0);
      o_halt     <= o_halt | (~stopped & (ex_ctrl == rv64_pkg::ex_ebreak));
      o_abort    <= o_abort | (~stopped & (ex_ctrl == rv64_pkg::ex_invalid));
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb_rd   <= rd;
    o_wb_data <= wb_data;
  end

endmodule

`default_nettype wire

//--- test/tb_rv64_core.sv
// testbench for the single-cycle rv64 core with instruction memory model and file-driven checks
`default_nettype none
`timescale 1ns/100ps

`include "rv64_defines.svh"

module tb_rv64_core;

  localparam int stim_depth   = 160;
  localparam int prog_depth   = 64;
  localparam int num_programs = 2;

  logic               i_clk;
  logic               i_rst;
  logic        [31:0] i_inst;
  rv64_pkg::xlen_t    o_pc;
  logic               o_wb_valid;
  rv64_pkg::reg_idx_t o_wb_rd;
  rv64_pkg::xlen_t    o_wb_data;
  logic               o_halt;
  logic               o_abort;

  logic [63:0] stim [stim_depth];
  logic [31:0] prog [prog_depth];
  int          prog_len;
  longint      limit_ns = 0;

  rv64_core i_rv64_core (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_inst     (i_inst),
    .o_pc       (o_pc),
    .o_wb_valid (o_wb_valid),
    .o_wb_rd    (o_wb_rd),
    .o_wb_data  (o_wb_data),
    .o_halt     (o_halt),
    .o_abort    (o_abort)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_wb(input rv64_pkg::reg_idx_t exp_rd, input rv64_pkg::xlen_t exp_data);
    if (o_wb_rd !== exp_rd) begin
      $display("MISMATCH time=%0t o_wb_rd expected %0d got %0d", $time, exp_rd, o_wb_rd);
      $display("Simulation failed");
      $fatal(1);
    end
    if (o_wb_data !== exp_data) begin
      $display("MISMATCH time=%0t o_wb_data expected %h got %h", $time, exp_data, o_wb_data);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_status(input logic exp_halt, input logic exp_abort);
    if (o_halt !== exp_halt) begin
      $display("MISMATCH time=%0t o_halt expected %b got %b", $time, exp_halt, o_halt);
      $display("Simulation failed");
      $fatal(1);
    end
    if (o_abort !== exp_abort) begin
      $display("MISMATCH time=%0t o_abort expected %b got %b", $time, exp_abort, o_abort);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // pc at its reset value and no write-back report
  task automatic verify_reset_state(input rv64_pkg::xlen_t exp_pc);
    if (o_pc !== exp_pc) begin
      $display("MISMATCH time=%0t o_pc expected %h got %h", $time, exp_pc, o_pc);
      $display("Simulation failed");
      $fatal(1);
    end
    if (o_wb_valid !== 1'b0) begin
      $display("MISMATCH time=%0t o_wb_valid expected 0 got %b", $time, o_wb_valid);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // instruction memory answers the current pc
  task automatic drive_inst();
    if (o_pc[1:0] != 2'b00 || o_pc >= 64'(prog_len * 4)) begin
      abort_run("program counter left the loaded program");
    end else begin
      i_inst = prog[o_pc[7:2]];
    end
  endtask

  task automatic run_program(inout int pos);
    int  n_wb;
    int  seen;
    bit  stop;
    prog_len = int'(stim[pos]);
    pos++;
    for (int i = 0; i < prog_len; i++) begin
      prog[i] = stim[pos][31:0];
      pos++;
    end
    n_wb = int'(stim[pos]);
    pos++;
    @(negedge i_clk);
    i_rst  = 1'b1;
    i_inst = prog[0];
    repeat (3) @(negedge i_clk);
    verify_reset_state(`RESET_PC);
    check_status(1'b0, 1'b0);
    i_rst = 1'b0;
    seen  = 0;
    stop  = 1'b0;
    while (!stop) begin
      @(negedge i_clk);
      if (o_wb_valid) begin
        if (seen >= n_wb) begin
          abort_run("register write-back reported where none was expected");
        end else begin
          check_wb(stim[pos + 2 * seen][4:0], stim[pos + 2 * seen + 1]);
          seen++;
        end
      end
      stop = o_halt | o_abort;
      drive_inst();
    end
    // core must stay quiet once stopped
    repeat (4) begin
      @(negedge i_clk);
      if (o_wb_valid) abort_run("register write-back reported after the core stopped");
    end
    if (seen != n_wb) abort_run("core stopped before all expected write-backs were seen");
    pos += 2 * n_wb;
    check_status(stim[pos][0], stim[pos + 1][0]);
    pos += 2;
  endtask

  initial begin
    int pos;
    int total;
    i_rst  = 1'b1;
    i_inst = 32'h0000_0013;
    $readmemh("test/rv64_stimulus.txt", stim);
    pos   = 0;
    total = 0;
    for (int p = 0; p < num_programs; p++) begin
      total += int'(stim[pos]) + 20;
      pos   += int'(stim[pos]) + 1;
      pos   += 2 * int'(stim[pos]) + 3;
    end
    limit_ns = longint'(total) * 4 * 4;
    pos = 0;
    for (int p = 0; p < num_programs; p++) begin
      run_program(pos);
    end
    $display("Simulation passed");
    $finish;
  end

  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    abort_run("watchdog timeout, the core never reached halt or abort");
  end

endmodule

`default_nettype wire

//--- test/rv64_stimulus.txt
// per program: word count, program words, write-back count, (rd data) pairs, halt, abort
// program 1 covers alu, word forms, muldiv, branches, jumps, loads and stores, then ebreak
3D
00500093 FFD00113 002081B3 40208233 001122B3 00113333 0FF14393 02809413
40115493 03C15513 123455B7 00001617 7FFFF737 00E707BB 40E0083B 002098BB
4017D93B 022709BB 02208A33 02224AB3 02226B33 02115BB3 02117C33 0200CCB3
0200ED33 00100D93 03FD9D93 FFF00E13 03CDCEB3 03CDEF33 00108463 00100F93
00109463 00700F93 00114463 00100F93 00116463 00900F93 00117463 00100F93
0020D463 00100F93 008002EF 00100F93 00C28367 00100F93 10203023 101000A3
10B01123 10F02223 10003383 10000403 10004483 10201503 10401583 10405603
10402683 10406703 10002803 00100073 00100F93
2B
01 0000000000000005
02 FFFFFFFFFFFFFFFD
03 0000000000000002
04 0000000000000008
05 0000000000000001
06 0000000000000000
07 FFFFFFFFFFFFFF02
08 0000050000000000
09 FFFFFFFFFFFFFFFE
0A 000000000000000F
0B 0000000012345000
0C 000000000000102C
0E 000000007FFFF000
0F FFFFFFFFFFFFE000
10 FFFFFFFF80001000
11 FFFFFFFFA0000000
12 FFFFFFFFFFFFFF00
13 FFFFFFFF80003000
14 FFFFFFFFFFFFFFF1
15 FFFFFFFFFFFFFFFE
16 0000000000000002
17 3333333333333332
18 0000000000000003
19 FFFFFFFFFFFFFFFF
1A 0000000000000005
1B 0000000000000001
1B 8000000000000000
1C FFFFFFFFFFFFFFFF
1D 8000000000000000
1E 0000000000000000
1F 0000000000000007
1F 0000000000000009
05 00000000000000AC
06 00000000000000B4
07 FFFFE000500005FD
08 FFFFFFFFFFFFFFFD
09 00000000000000FD
0A 0000000000005000
0B FFFFFFFFFFFFE000
0C 000000000000E000
0D FFFFFFFFFFFFE000
0E 00000000FFFFE000
10 00000000500005FD
1 0
// program 2 hits an invalid word after one write
3
00500093 FFFFFFFF FFD00113
1
01 0000000000000005
0 1

//--- rv64_core.f
+incdir+common
common/rv64_pkg.sv
idu/rv64_idu.sv
exu/rv64_exu.sv
rtl/rv64_regfile.sv
rtl/rv64_lsu.sv
rtl/rv64_core.sv
test/tb_rv64_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rv64 core testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f rv64_core.f --top-module tb_rv64_core -o sim_rv64_core

./obj_dir/sim_rv64_core
